//--- project.f
verilog/floo_vc_router_pkg.sv
verilog/floo_rr_arbiter.sv
verilog/floo_vc_input_port.sv
verilog/floo_sa_local.sv
verilog/floo_sa_global.sv
verilog/floo_lookahead_route.sv
verilog/floo_vc_router.sv
sim/floo_tb_clkgen.sv
sim/floo_vc_router_chk.sv
sim/floo_vc_router_tb.sv

//--- sim/floo_vc_router_tb.sv
//******************************
// directed testbench of the vc mesh router
// router sits at (1,1); a negedge monitor logs every
// output transfer, tests pop and compare those records
//******************************
`timescale 1ns/1ps
`default_nettype none

module floo_vc_router_tb;

  import floo_vc_router_pkg::*;

  localparam int timeout_cycles = 200;
  localparam int my_x           = 1;
  localparam int my_y           = 1;

  logic                  clk;
  logic                  arst_n;
  logic [num_ports-1:0]  in_valid;
  flit_t [num_ports-1:0] in_flit;
  logic [num_ports-1:0]  in_ready;
  logic [num_ports-1:0]  out_valid;
  flit_t [num_ports-1:0] out_flit;
  logic [num_ports-1:0]  out_ready;

  int     errors;
  int     tests;
  int     cycle_cnt;
  integer seed = 6304;

  // transfers seen at the outputs, in order
  flit_t rx_flit_q [$];
  int    rx_port_q [$];
  int    rx_edge_q [$];

  // random test bookkeeping per input-vc pair
  flit_t sent_mem [10][200];

  floo_tb_clkgen u_clkgen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  floo_vc_router u_floo_vc_router (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .id_x_i      (2'd1),
    .id_y_i      (2'd1),
    .in_valid_i  (in_valid),
    .in_flit_i   (in_flit),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .out_flit_o  (out_flit),
    .out_ready_i (out_ready)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // mid-cycle sample, transfer happens at the coming edge
  always @(negedge clk) begin
    if (arst_n) begin
      for (int o = 0; o < num_ports; o++) begin
        if (out_valid[o] && out_ready[o]) begin
          rx_flit_q.push_back(out_flit[o]);
          rx_port_q.push_back(o);
          rx_edge_q.push_back(cycle_cnt + 1);
        end
      end
    end
  end

  // next-hop direction as seen from the neighbour behind out_port
  function automatic route_dir_e la_model(input int out_port, input flit_t f);
    int nx;
    int ny;
    nx = my_x;
    ny = my_y;
    if (out_port == 0) begin
      return f.lookahead;
    end
    if (out_port == 1) ny = ny + 1;
    if (out_port == 3) ny = ny - 1;
    if (out_port == 2) nx = nx + 1;
    if (out_port == 4) nx = nx - 1;
    if (int'(f.dst_x) > nx) return dir_east;
    if (int'(f.dst_x) < nx) return dir_west;
    if (int'(f.dst_y) > ny) return dir_north;
    if (int'(f.dst_y) < ny) return dir_south;
    return dir_local;
  endfunction

  function automatic flit_t make_flit(input logic [15:0] pl, input int dx, input int dy,
                                      input int la, input int vc);
    flit_t f;
    f.payload   = pl;
    f.dst_x     = coord_width'(dx);
    f.dst_y     = coord_width'(dy);
    f.lookahead = route_dir_e'(la);
    f.vc_id     = vc_id_width'(vc);
    return f;
  endfunction

  task automatic check_flit(input string name, input flit_t got, input flit_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_dir(input string name, input route_dir_e got, input route_dir_e exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // present flits on the masked inputs until each is taken
  task automatic drive_flits(input logic [num_ports-1:0] mask, input flit_t [num_ports-1:0] f,
                             output int acc_edge);
    logic [num_ports-1:0] pend;
    logic [num_ports-1:0] acc;
    int                   t;
    acc_edge = 0;
    @(posedge clk);
    #1;
    pend = mask;
    for (int p = 0; p < num_ports; p++) begin
      if (mask[p]) in_flit[p] = f[p];
    end
    in_valid = pend;
    t = 0;
    while (pend != '0 && t < timeout_cycles) begin
      @(negedge clk);
      acc = pend & in_ready;
      if (acc != '0) acc_edge = cycle_cnt + 1;
      @(posedge clk);
      #1;
      pend     = pend & ~acc;
      in_valid = pend;
      t++;
    end
    if (pend != '0) begin
      $display("timeout: input flits not accepted, pending mask %h", pend);
      in_valid = '0;
      errors++;
    end
  endtask

  task automatic send_one(input int port, input flit_t f, output int acc_edge);
    flit_t [num_ports-1:0] fa;
    fa       = '0;
    fa[port] = f;
    drive_flits(num_ports'(1) << port, fa, acc_edge);
  endtask

  task automatic wait_rx(input int n);
    int t;
    t = 0;
    while (rx_flit_q.size() < n && t < timeout_cycles) begin
      @(posedge clk);
      t++;
    end
    if (rx_flit_q.size() < n) begin
      $display("timeout: %0d of %0d flits arrived", rx_flit_q.size(), n);
      errors++;
    end
  endtask

  // pops one record and checks port and contents against the sent flit
  task automatic expect_rx(input string name, input int port, input flit_t sent);
    flit_t exp;
    if (rx_flit_q.size() == 0) begin
      $display("%s: no flit received", name);
      errors++;
    end else begin
      exp           = sent;
      exp.lookahead = la_model(port, sent);
      check_dir({name, " port"}, route_dir_e'(rx_port_q[0]), route_dir_e'(port));
      check_flit({name, " flit"}, rx_flit_q.pop_front(), exp);
      void'(rx_port_q.pop_front());
      void'(rx_edge_q.pop_front());
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests++;
    $display("test %s: %s (%0d errors)", name,
             (errors == err_before) ? "ok" : "failed", errors - err_before);
  endtask

  task automatic test_single();
    int    e0;
    int    acc;
    int    port;
    flit_t f;
    e0 = errors;
    for (int p = 0; p < num_ports; p++) begin
      // west input ends on east, leaving that pointer at 0
      port = (p + 3) % num_ports;
      f    = make_flit(16'h1000 + p, p % 4, (p + 1) % 4, port, p % 2);
      send_one(p, f, acc);
      wait_rx(1);
      if (rx_edge_q.size() > 0 && rx_edge_q[0] != acc + 1) begin
        $display("input %0d flit left after %0d cycles, expected 1", p, rx_edge_q[0] - acc);
        errors++;
      end
      expect_rx("single", port, f);
    end
    finish_test("single_route", e0);
  endtask

  task automatic test_global_rr();
    int                    e0;
    int                    acc;
    flit_t [num_ports-1:0] fa;
    e0 = errors;
    fa    = '0;
    fa[0] = make_flit(16'h2000, 3, 1, 2, 0);
    fa[1] = make_flit(16'h2001, 3, 2, 2, 0);
    fa[4] = make_flit(16'h2004, 2, 1, 2, 0);
    @(posedge clk);
    #1 out_ready[2] = 1'b0;
    drive_flits(5'b10011, fa, acc);
    @(posedge clk);
    #1 out_ready[2] = 1'b1;
    wait_rx(3);
    expect_rx("rr1 local", 2, fa[0]);
    expect_rx("rr1 north", 2, fa[1]);
    expect_rx("rr1 west", 2, fa[4]);
    // lone north flit moves the east pointer to 2
    send_one(1, make_flit(16'h2101, 3, 0, 2, 0), acc);
    wait_rx(1);
    expect_rx("rr2 lone", 2, make_flit(16'h2101, 3, 0, 2, 0));
    @(posedge clk);
    #1 out_ready[2] = 1'b0;
    drive_flits(5'b10011, fa, acc);
    @(posedge clk);
    #1 out_ready[2] = 1'b1;
    wait_rx(3);
    expect_rx("rr2 west", 2, fa[4]);
    expect_rx("rr2 local", 2, fa[0]);
    expect_rx("rr2 north", 2, fa[1]);
    finish_test("global_rr", e0);
  endtask

  task automatic test_local_rr();
    int    e0;
    int    acc;
    int    prev_vc;
    flit_t f [4];
    e0 = errors;
    @(posedge clk);
    #1 out_ready[1] = 1'b0;
    for (int k = 0; k < 4; k++) begin
      f[k] = make_flit(16'h3000 + k, 1, 3, 1, k % 2);
      send_one(0, f[k], acc);
    end
    @(posedge clk);
    #1 out_ready[1] = 1'b1;
    wait_rx(4);
    prev_vc = -1;
    // flit 0 is granted alone and held, then vc 1 and vc 0 take turns
    for (int k = 0; k < 4 && rx_flit_q.size() > 0; k++) begin
      if (int'(rx_flit_q[0].vc_id) == prev_vc) begin
        $display("vc %0d served twice in a row", prev_vc);
        errors++;
      end
      prev_vc = int'(rx_flit_q[0].vc_id);
      expect_rx("local_rr", 1, f[k]);
    end
    finish_test("local_vc_rr", e0);
  endtask

  task automatic test_backpressure();
    int    e0;
    int    acc;
    int    t;
    flit_t exp0;
    flit_t f0;
    flit_t f1;
    e0 = errors;
    f0 = make_flit(16'h4000, 0, 1, 4, 0);
    f1 = make_flit(16'h4001, 0, 2, 4, 0);
    // oldest flit of the vc sits on the stalled output
    exp0           = f0;
    exp0.lookahead = la_model(4, f0);
    @(posedge clk);
    #1 out_ready[4] = 1'b0;
    send_one(2, f0, acc);
    send_one(2, f1, acc);
    t = 0;
    @(negedge clk);
    while (!out_valid[4] && t < timeout_cycles) begin
      @(negedge clk);
      t++;
    end
    check_bit("out_valid_o[4]", out_valid[4], 1'b1);
    check_flit("out_flit_o[4]", out_flit[4], exp0);
    repeat (5) begin
      @(negedge clk);
      check_bit("out_valid_o[4]", out_valid[4], 1'b1);
      check_flit("out_flit_o[4]", out_flit[4], exp0);
    end
    check_bit("no transfer while stalled", rx_flit_q.size() == 0, 1'b1);
    @(posedge clk);
    #1 out_ready[4] = 1'b1;
    wait_rx(2);
    expect_rx("bp first", 4, f0);
    expect_rx("bp second", 4, f1);
    finish_test("backpressure", e0);
  endtask

  task automatic test_vc_full();
    int    e0;
    int    acc;
    flit_t f0;
    flit_t f1;
    e0 = errors;
    f0 = make_flit(16'h5000, 1, 0, 3, 0);
    f1 = make_flit(16'h5001, 1, 0, 3, 0);
    @(posedge clk);
    #1 out_ready[3] = 1'b0;
    send_one(4, f0, acc);
    send_one(4, f1, acc);
    // probe ready with valid low, it only looks at vc_id
    @(posedge clk);
    #1 in_flit[4] = make_flit(16'h5002, 1, 0, 3, 0);
    @(negedge clk);
    check_bit("in_ready_o[4] vc0", in_ready[4], 1'b0);
    @(posedge clk);
    #1 in_flit[4] = make_flit(16'h5003, 1, 0, 3, 1);
    @(negedge clk);
    check_bit("in_ready_o[4] vc1", in_ready[4], 1'b1);
    @(posedge clk);
    #1 out_ready[3] = 1'b1;
    wait_rx(2);
    expect_rx("full first", 3, f0);
    expect_rx("full second", 3, f1);
    finish_test("vc_full", e0);
  endtask

  task automatic test_random();
    int                   e0;
    int                   sent;
    int                   got;
    int                   t;
    int                   pair;
    int                   seq;
    int                   vc;
    int                   next_seq [10];
    int                   seq_cnt [10];
    logic [num_ports-1:0] pend;
    logic [num_ports-1:0] acc;
    flit_t                f;
    e0   = errors;
    sent = 0;
    got  = 0;
    t    = 0;
    pend = '0;
    acc  = '0;
    for (int k = 0; k < 10; k++) begin
      next_seq[k] = 0;
      seq_cnt[k]  = 0;
    end
    while ((sent < 200 || pend != '0 || got < 200) && t < 6000) begin
      @(posedge clk);
      #1;
      pend = pend & ~acc;
      for (int p = 0; p < num_ports; p++) begin
        if (!pend[p] && sent < 200 && ($random(seed) & 1)) begin
          vc   = $random(seed) & 1;
          pair = p * 2 + vc;
          seq  = seq_cnt[pair];
          seq_cnt[pair]++;
          f = make_flit({pair[3:0], seq[11:0]}, $random(seed) & 3, $random(seed) & 3,
                        $unsigned($random(seed)) % num_ports, vc);
          sent_mem[pair][seq] = f;
          in_flit[p] = f;
          pend[p]    = 1'b1;
          sent++;
        end
      end
      in_valid  = pend;
      out_ready = (sent >= 200) ? '1 : num_ports'($random(seed) | $random(seed));
      // scoreboard on everything logged so far
      while (rx_flit_q.size() > 0) begin
        pair = rx_flit_q[0].payload[15:12];
        seq  = rx_flit_q[0].payload[11:0];
        if (pair >= 10 || seq != next_seq[pair]) begin
          $display("random flit %h arrived out of order or twice", rx_flit_q[0]);
          errors++;
          void'(rx_flit_q.pop_front());
          void'(rx_port_q.pop_front());
          void'(rx_edge_q.pop_front());
        end else begin
          next_seq[pair]++;
          expect_rx("random", sent_mem[pair][seq].lookahead, sent_mem[pair][seq]);
        end
        got++;
      end
      @(negedge clk);
      acc = pend & in_ready;
      t++;
    end
    in_valid  = '0;
    out_ready = '1;
    if (got != 200) begin
      $display("random traffic delivered %0d of 200 flits", got);
      errors++;
    end
    finish_test("random", e0);
  endtask

  initial begin
    in_valid  = '0;
    in_flit   = '0;
    out_ready = '1;
    errors    = 0;
    tests     = 0;
    cycle_cnt = 0;
    @(posedge arst_n);
    repeat (2) @(posedge clk);
    test_single();
    test_global_rr();
    test_local_rr();
    test_backpressure();
    test_vc_full();
    test_random();
    $display("tests run: %0d, errors: %0d", tests, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/floo_vc_router_chk.sv
//******************************
// concurrent checks bound into the router top
// output handshake stability, grant shape, reset state
//******************************
`timescale 1ns/1ps
`default_nettype none

module floo_vc_router_chk (
  input logic                                                      clk_i,
  input logic                                                      arst_n_i,
  input logic [floo_vc_router_pkg::num_ports-1:0]                  out_valid_o,
  input floo_vc_router_pkg::flit_t [floo_vc_router_pkg::num_ports-1:0] out_flit_o,
  input logic [floo_vc_router_pkg::num_ports-1:0]                  out_ready_i,
  input logic [floo_vc_router_pkg::num_ports-1:0][floo_vc_router_pkg::num_ports-1:0]
              out_grant_i
);

  import floo_vc_router_pkg::*;

  for (genvar p = 0; p < num_ports; p++) begin : gen_port
    // stalled output keeps valid and flit
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_valid_o[p] && !out_ready_i[p] |=> out_valid_o[p] && $stable(out_flit_o[p]))
      else $error("output %0d changed while stalled", p);

    // at most one input granted per output
    assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(out_grant_i[p]))
      else $error("output %0d grant not one-hot", p);
  end

  // nothing leaves while in reset
  assert property (@(posedge clk_i) !arst_n_i |-> out_valid_o == '0)
    else $error("output valid during reset");

endmodule

bind floo_vc_router floo_vc_router_chk u_floo_vc_router_chk (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .out_valid_o (out_valid_o),
  .out_flit_o  (out_flit_o),
  .out_ready_i (out_ready_i),
  .out_grant_i (out_grant)
);

`default_nettype wire

//--- sim/floo_tb_clkgen.sv
//******************************
// testbench clock and reset source
// 10 ns clock, reset held low for 16 cycles
//******************************
`timescale 1ns/1ps
`default_nettype none

module floo_tb_clkgen (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #5 clk_o = ~clk_o;
    end
  end

  // release a little after an edge
  initial begin
    arst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- verilog/floo_vc_router.sv
//******************************
// five-port vc mesh router, single-flit packets
// input buffers, two-stage switch allocation, crossbar
// and lookahead routing; valid/ready on every port
//******************************
`timescale 1ns/1ps
`default_nettype none

module floo_vc_router (
  input  logic                                                     clk_i,
  input  logic                                                     arst_n_i,
  input  logic [floo_vc_router_pkg::coord_width-1:0]               id_x_i,
  input  logic [floo_vc_router_pkg::coord_width-1:0]               id_y_i,
  input  logic [floo_vc_router_pkg::num_ports-1:0]                 in_valid_i,
  input  floo_vc_router_pkg::flit_t [floo_vc_router_pkg::num_ports-1:0] in_flit_i,
  output logic [floo_vc_router_pkg::num_ports-1:0]                 in_ready_o,
  output logic [floo_vc_router_pkg::num_ports-1:0]                 out_valid_o,
  output floo_vc_router_pkg::flit_t [floo_vc_router_pkg::num_ports-1:0] out_flit_o,
  input  logic [floo_vc_router_pkg::num_ports-1:0]                 out_ready_i
);

  import floo_vc_router_pkg::*;

  // vc heads per input
  logic  [num_ports-1:0][num_vc-1:0]      head_valid;
  flit_t [num_ports-1:0][num_vc-1:0]      head_flit;
  logic  [num_ports-1:0][num_vc-1:0]      pop;
  // local allocation results per input
  logic  [num_ports-1:0]                  sa_v;
  logic  [num_ports-1:0][vc_id_width-1:0] sa_vc_id;
  logic  [num_ports-1:0][num_vc-1:0]      sa_vc_oh;
  logic  [num_ports-1:0][num_ports-1:0]   req_dir_oh;
  flit_t [num_ports-1:0]                  sa_flit;
  // global allocation, out_grant is [output][input]
  logic  [num_ports-1:0][num_ports-1:0]   out_grant;
  logic  [num_ports-1:0]                  in_grant;
  logic  [num_ports-1:0]                  in_xfer;
  logic  [num_ports-1:0]                  out_xfer;
  flit_t [num_ports-1:0]                  xbar_flit;

  for (genvar i = 0; i < num_ports; i++) begin : gen_in
    floo_vc_input_port u_in_port (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .in_valid_i   (in_valid_i[i]),
      .in_flit_i    (in_flit_i[i]),
      .in_ready_o   (in_ready_o[i]),
      .pop_i        (pop[i]),
      .head_valid_o (head_valid[i]),
      .head_flit_o  (head_flit[i])
    );

    floo_sa_local u_sa_local (
      .clk_i                    (clk_i),
      .arst_n_i                 (arst_n_i),
      .vc_head_valid_i          (head_valid[i]),
      .vc_head_i                (head_flit[i]),
      .update_rr_arb_i          (in_xfer[i]),
      .sa_local_v_o             (sa_v[i]),
      .sa_local_vc_id_o         (sa_vc_id[i]),
      .sa_local_vc_id_oh_o      (sa_vc_oh[i]),
      .sa_local_output_dir_oh_o (req_dir_oh[i])
    );

    // chosen head of this input
    assign sa_flit[i] = head_flit[i][sa_vc_id[i]];
    // granted and the requested output takes it
    assign in_xfer[i] = sa_v[i] && in_grant[i] && (|(req_dir_oh[i] & out_ready_i));
    assign pop[i]     = sa_vc_oh[i] & {num_vc{in_xfer[i]}};
  end

  floo_sa_global u_sa_global (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_dir_oh_i (req_dir_oh),
    .update_i     (out_xfer),
    .out_grant_o  (out_grant),
    .in_grant_o   (in_grant)
  );

  // crossbar, one-hot grant selects the input
  always_comb begin
    xbar_flit = '0;
    for (int o = 0; o < num_ports; o++) begin
      for (int i = 0; i < num_ports; i++) begin
        if (out_grant[o][i]) begin
          xbar_flit[o] = sa_flit[i];
        end
      end
    end
  end

  for (genvar o = 0; o < num_ports; o++) begin : gen_out
    assign out_valid_o[o] = |out_grant[o];
    assign out_xfer[o]    = out_valid_o[o] && out_ready_i[o];

    // next hop direction written on the way out
    floo_lookahead_route u_la_route (
      .out_dir_i (route_dir_e'(o)),
      .id_x_i    (id_x_i),
      .id_y_i    (id_y_i),
      .flit_i    (xbar_flit[o]),
      .flit_o    (out_flit_o[o])
    );
  end

endmodule

`default_nettype wire

//--- verilog/floo_lookahead_route.sv
//******************************
// lookahead routing for flits leaving one output
// computes the xy direction to take at the neighbour router
//******************************
`timescale 1ns/1ps
`default_nettype none

module floo_lookahead_route (
  input  floo_vc_router_pkg::route_dir_e              out_dir_i,
  input  logic [floo_vc_router_pkg::coord_width-1:0]  id_x_i,
  input  logic [floo_vc_router_pkg::coord_width-1:0]  id_y_i,
  input  floo_vc_router_pkg::flit_t                   flit_i,
  output floo_vc_router_pkg::flit_t                   flit_o
);

  import floo_vc_router_pkg::*;

  // coordinates of the router behind this output
  logic [coord_width-1:0] nxt_x;
  logic [coord_width-1:0] nxt_y;
  route_dir_e             next_dir;

  // y grows towards north
  always_comb begin
    nxt_x = id_x_i;
    nxt_y = id_y_i;
    case (out_dir_i)
      dir_north: nxt_y = id_y_i + 1'b1;
      dir_south: nxt_y = id_y_i - 1'b1;
      dir_east:  nxt_x = id_x_i + 1'b1;
      dir_west:  nxt_x = id_x_i - 1'b1;
      default:   ;
    endcase
  end

  // x first, then y, then eject
  always_comb begin
    if (flit_i.dst_x > nxt_x)      next_dir = dir_east;
    else if (flit_i.dst_x < nxt_x) next_dir = dir_west;
    else if (flit_i.dst_y > nxt_y) next_dir = dir_north;
    else if (flit_i.dst_y < nxt_y) next_dir = dir_south;
    else                           next_dir = dir_local;
  end

  // ejected flits keep their field
  always_comb begin
    flit_o = flit_i;
    if (out_dir_i != dir_local) begin
      flit_o.lookahead = next_dir;
    end
  end

endmodule

`default_nettype wire

//--- verilog/floo_sa_global.sv
//******************************
// global switch allocation
// one round-robin arbiter per output over the input requests
// gives one-hot grants per output and a grant bit per input
//******************************
`timescale 1ns/1ps
`default_nettype none

module floo_sa_global (
  input  logic clk_i,
  input  logic arst_n_i,
  // [input][output]
  input  logic [floo_vc_router_pkg::num_ports-1:0][floo_vc_router_pkg::num_ports-1:0]
               req_dir_oh_i,
  // per output, a transfer took place
  input  logic [floo_vc_router_pkg::num_ports-1:0] update_i,
  // [output][input]
  output logic [floo_vc_router_pkg::num_ports-1:0][floo_vc_router_pkg::num_ports-1:0]
               out_grant_o,
  output logic [floo_vc_router_pkg::num_ports-1:0] in_grant_o
);

  import floo_vc_router_pkg::*;

  // requests regrouped per output, [output][input]
  logic [num_ports-1:0][num_ports-1:0] req_per_out;

  for (genvar o = 0; o < num_ports; o++) begin : gen_out
    for (genvar i = 0; i < num_ports; i++) begin : gen_tr
      assign req_per_out[o][i] = req_dir_oh_i[i][o];
    end

    // index only needed inside the arbiter
    floo_rr_arbiter #(
      .num_inputs (num_ports)
    ) u_out_arb (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .req_i      (req_per_out[o]),
      .update_i   (update_i[o]),
      .grant_o    (out_grant_o[o]),
      .grant_id_o ()
    );
  end

  // an input asks for one output at most, so OR of its column is enough
  always_comb begin
    in_grant_o = '0;
    for (int i = 0; i < num_ports; i++) begin
      for (int o = 0; o < num_ports; o++) begin
        in_grant_o[i] = in_grant_o[i] | out_grant_o[o][i];
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/floo_sa_local.sv
//******************************
// local switch allocation of one input port
// picks a valid vc round-robin and turns its lookahead
// into a one-hot request towards the outputs
//******************************
`timescale 1ns/1ps
`default_nettype none

module floo_sa_local (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  logic [floo_vc_router_pkg::num_vc-1:0]        vc_head_valid_i,
  input  floo_vc_router_pkg::flit_t [floo_vc_router_pkg::num_vc-1:0] vc_head_i,
  input  logic                                         update_rr_arb_i,
  output logic                                         sa_local_v_o,
  output logic [floo_vc_router_pkg::vc_id_width-1:0]   sa_local_vc_id_o,
  output logic [floo_vc_router_pkg::num_vc-1:0]        sa_local_vc_id_oh_o,
  output logic [floo_vc_router_pkg::num_ports-1:0]     sa_local_output_dir_oh_o
);

  import floo_vc_router_pkg::*;

  // vc choice, only advances once the flit has left
  floo_rr_arbiter #(
    .num_inputs (num_vc)
  ) u_vc_arb (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .req_i      (vc_head_valid_i),
    .update_i   (update_rr_arb_i),
    .grant_o    (sa_local_vc_id_oh_o),
    .grant_id_o (sa_local_vc_id_o)
  );

  // any valid head means a vc gets chosen
  assign sa_local_v_o = |vc_head_valid_i;

  // one bit per output, all zero without a valid vc
  always_comb begin
    for (int p = 0; p < num_ports; p++) begin
      sa_local_output_dir_oh_o[p] = sa_local_v_o &&
          (vc_head_i[sa_local_vc_id_o].lookahead == route_dir_e'(p));
    end
  end

endmodule

`default_nettype wire

//--- verilog/floo_vc_input_port.sv
//******************************
// input buffer of one router port
// one small circular fifo per vc, selected by the flit's vc_id
// heads are presented to the local switch allocator
//******************************
`timescale 1ns/1ps
`default_nettype none

module floo_vc_input_port (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic                                      in_valid_i,
  input  floo_vc_router_pkg::flit_t                 in_flit_i,
  output logic                                      in_ready_o,
  input  logic [floo_vc_router_pkg::num_vc-1:0]     pop_i,
  output logic [floo_vc_router_pkg::num_vc-1:0]     head_valid_o,
  output floo_vc_router_pkg::flit_t [floo_vc_router_pkg::num_vc-1:0] head_flit_o
);

  import floo_vc_router_pkg::*;

  logic [num_vc-1:0] vc_full;
  logic [num_vc-1:0] push;

  // circular increment, safe for non power of two depth
  function automatic logic [fifo_ptr_width-1:0] ptr_inc(input logic [fifo_ptr_width-1:0] p);
    return (p == fifo_ptr_width'(fifo_depth - 1)) ? '0 : p + 1'b1;
  endfunction

  // ready only reflects the vc the current flit is addressed to
  assign in_ready_o = !vc_full[in_flit_i.vc_id];

  for (genvar v = 0; v < num_vc; v++) begin : gen_vc
    flit_t                     mem_q [fifo_depth];
    logic [fifo_ptr_width-1:0] wr_ptr_q;
    logic [fifo_ptr_width-1:0] rd_ptr_q;
    logic [fifo_cnt_width-1:0] count_q;

    assign push[v]         = in_valid_i && in_ready_o && (in_flit_i.vc_id == vc_id_width'(v));
    assign vc_full[v]      = (count_q == fifo_cnt_width'(fifo_depth));
    assign head_valid_o[v] = (count_q != '0);
    assign head_flit_o[v]  = mem_q[rd_ptr_q];

    // payload storage
    always_ff @(posedge clk_i) begin
      if (push[v]) begin
        mem_q[wr_ptr_q] <= in_flit_i;
      end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push[v]) begin
          wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (pop_i[v]) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        // simultaneous push and pop leaves the count alone
        case ({push[v], pop_i[v]})
          2'b10:   count_q <= count_q + 1'b1;
          2'b01:   count_q <= count_q - 1'b1;
          default: count_q <= count_q;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/floo_rr_arbiter.sv
//******************************
// round-robin arbiter with a rotating priority pointer
// pointer advances past the grantee only on update_i
// an unfinished grant is held until its update
//******************************
`timescale 1ns/1ps
`default_nettype none

module floo_rr_arbiter #(
  parameter int num_inputs = 2,
  parameter int id_width   = (num_inputs > 1) ? $clog2(num_inputs) : 1
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic [num_inputs-1:0] req_i,
  input  logic                  update_i,
  output logic [num_inputs-1:0] grant_o,
  output logic [id_width-1:0]   grant_id_o
);

  // first index searched
  logic [id_width-1:0] ptr_q;
  // grant of last cycle still waiting for its update
  logic                lock_q;
  logic [id_width-1:0] lock_id_q;

  always_comb begin
    int   idx;
    logic found;
    grant_o    = '0;
    grant_id_o = '0;
    found      = 1'b0;
    // keep a pending grant so the granted data stays stable
    if (lock_q && req_i[lock_id_q]) begin
      grant_o[lock_id_q] = 1'b1;
      grant_id_o         = lock_id_q;
      found              = 1'b1;
    end
    // otherwise first requester at or after the pointer
    for (int i = 0; i < num_inputs; i++) begin
      idx = int'(ptr_q) + i;
      if (idx >= num_inputs) begin
        idx = idx - num_inputs;
      end
      if (!found && req_i[idx]) begin
        grant_o[idx] = 1'b1;
        grant_id_o   = id_width'(idx);
        found        = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q     <= '0;
      lock_q    <= 1'b0;
      lock_id_q <= '0;
    end else begin
      // lock released by the update strobe
      lock_q    <= (|req_i) && !update_i;
      lock_id_q <= grant_id_o;
      // move to grantee plus one, wrap at num_inputs
      if (update_i && (|req_i)) begin
        if (grant_id_o == id_width'(num_inputs - 1)) begin
          ptr_q <= '0;
        end else begin
          ptr_q <= grant_id_o + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/floo_vc_router_pkg.sv
//******************************
// shared sizes and types of the vc mesh router
// import with floo_vc_router_pkg::* inside a module body
// and use scoped names in module headers
//******************************
`default_nettype none

package floo_vc_router_pkg;

  // router geometry
  localparam int num_ports     = 5;
  localparam int num_vc        = 2;
  localparam int vc_id_width   = 1;

  // per-vc buffering
  localparam int fifo_depth     = 2;
  localparam int fifo_ptr_width = $clog2(fifo_depth);
  // count has to reach fifo_depth itself
  localparam int fifo_cnt_width = $clog2(fifo_depth + 1);

  // flit fields
  localparam int coord_width   = 2;
  localparam int payload_width = 16;

  // direction encoding, value is also the port index
  typedef enum logic [2:0] {
    dir_local = 3'd0,
    dir_north = 3'd1,
    dir_east  = 3'd2,
    dir_south = 3'd3,
    dir_west  = 3'd4
  } route_dir_e;

  // single-flit packet, 24 bits
  typedef struct packed {
    logic [payload_width-1:0] payload;
    logic [coord_width-1:0]   dst_x;
    logic [coord_width-1:0]   dst_y;
    // output to take at the next router
    route_dir_e               lookahead;
    logic [vc_id_width-1:0]   vc_id;
  } flit_t;

endpackage

`default_nettype wire
